//--- mul_pkg.sv
// ------------------------------
// integer multiplier package
// widths, skip limit, FSM states
// ------------------------------

package mul_pkg;

  // operand and product width, one word
  localparam int MUL_WIDTH = 32;

  // input message carries both operands
  localparam int MSG_WIDTH = 2 * MUL_WIDTH;

  // shift amounts and step count, 0 to MUL_WIDTH
  localparam int SHAMT_WIDTH = $clog2(MUL_WIDTH + 1);

  // most zero bits consumed per cycle
  localparam int MAX_SKIP = 6;

  // control FSM states
  typedef enum logic [1:0] {
    idle = 2'd0,
    calc = 2'd1,
    done = 2'd2
  } mul_state_t;

endpackage

//--- mul_ctrl_if.sv
// ------------------------------
// control / datapath link
// commands down, status back up
// ------------------------------

`timescale 1ns/10ps

interface mul_ctrl_if;

  // commands from control unit
  logic load;
  logic step;
  logic accumulate;

  // status from datapath
  logic mplier_lsb;
  logic steps_done;

  // control unit side
  modport ctrl (
    output load,
    output step,
    output accumulate,
    input  mplier_lsb,
    input  steps_done
  );

  // datapath side
  modport dpath (
    input  load,
    input  step,
    input  accumulate,
    output mplier_lsb,
    output steps_done
  );

endinterface

//--- zero_skip_shifter.sv
// ------------------------------
// zero skipping right shifter
// drops trailing zeros of the multiplier, reports the distance
// ------------------------------

`timescale 1ns/10ps

module zero_skip_shifter import mul_pkg::*; (
  input  logic [MUL_WIDTH-1:0]   mplier,
  input  logic [SHAMT_WIDTH-1:0] span,
  output logic [MUL_WIDTH-1:0]   shifted,
  output logic [SHAMT_WIDTH-1:0] amount
);

  // working copies for the skip chain
  logic [MUL_WIDTH-1:0]   skip_val;
  logic [SHAMT_WIDTH-1:0] skip_cnt;

  // ------------------------------
  // skip chain
  // ------------------------------

  // walk up to MAX_SKIP zero bits
  // once a one shows up or span runs out, later stages hold
  always_comb begin
    skip_val = mplier;
    skip_cnt = '0;
    for (int i = 0; i < MAX_SKIP; i++) begin
      if (skip_val[0] == 1'b0 && skip_cnt < span) begin
        skip_val = skip_val >> 1;
        skip_cnt = skip_cnt + SHAMT_WIDTH'(1);
      end
    end
  end

  // ------------------------------
  // output select
  // ------------------------------

  always_comb begin
    if (mplier[0]) begin
      // set bit, consume exactly one position
      shifted = mplier >> 1;
      amount  = SHAMT_WIDTH'(1);
    end else begin
      // zero run, take the skip chain
      shifted = skip_val;
      amount  = skip_cnt;
    end
  end

endmodule

//--- step_counter.sv
// ------------------------------
// consumed bit counter
// variable step add, remaining span, completion flag
// ------------------------------

`timescale 1ns/10ps

module step_counter import mul_pkg::*; (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   clear,
  input  logic                   advance,
  input  logic [SHAMT_WIDTH-1:0] amount,
  output logic [SHAMT_WIDTH-1:0] span,
  output logic                   full
);

  // bits consumed so far, 0 to MUL_WIDTH
  logic [SHAMT_WIDTH-1:0] count;
  // candidate next value, before the cap
  logic [SHAMT_WIDTH-1:0] count_sum;

  // worst case 32 + 6 still fits in 6 bits
  assign count_sum = count + amount;

  // ------------------------------
  // count register
  // ------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (clear) begin
      count <= '0;
    end else if (advance) begin
      // never run past the word width
      if (count_sum > SHAMT_WIDTH'(MUL_WIDTH)) begin
        count <= SHAMT_WIDTH'(MUL_WIDTH);
      end else begin
        count <= count_sum;
      end
    end
  end

  // positions still left in the multiplier
  assign span = SHAMT_WIDTH'(MUL_WIDTH) - count;

  // all bits consumed
  assign full = (count == SHAMT_WIDTH'(MUL_WIDTH));

endmodule

//--- mul_dpath.sv
// ------------------------------
// multiplier datapath
// operand and accumulator registers, shifters, adder
// ------------------------------

`timescale 1ns/10ps

module mul_dpath import mul_pkg::*; (
  input  logic                 clk,
  input  logic                 reset,
  input  logic [MSG_WIDTH-1:0] in_msg,
  output logic [MUL_WIDTH-1:0] out_msg,
  mul_ctrl_if.dpath            ctl
);

  // operand registers
  logic [MUL_WIDTH-1:0] mcand;
  logic [MUL_WIDTH-1:0] mplier;

  // running partial product
  logic [MUL_WIDTH-1:0] acc;

  // shifter results
  logic [MUL_WIDTH-1:0]   mplier_next;
  logic [SHAMT_WIDTH-1:0] shamt;

  // remaining positions from the counter
  logic [SHAMT_WIDTH-1:0] span;

  // adder output, wraps mod 2^32
  logic [MUL_WIDTH-1:0] acc_sum;

  // ------------------------------
  // shift and count
  // ------------------------------

  zero_skip_shifter u_shifter (
    .mplier  (mplier),
    .span    (span),
    .shifted (mplier_next),
    .amount  (shamt)
  );

  // load restarts the count, each step adds the shift amount
  step_counter u_counter (
    .clk     (clk),
    .reset   (reset),
    .clear   (ctl.load),
    .advance (ctl.step),
    .amount  (shamt),
    .span    (span),
    .full    (ctl.steps_done)
  );

  assign acc_sum = acc + mcand;

  // ------------------------------
  // registers
  // ------------------------------

  // multiplicand high half, multiplier low half
  // both operands move together on step
  always_ff @(posedge clk) begin
    if (ctl.load) begin
      mcand  <= in_msg[MSG_WIDTH-1:MUL_WIDTH];
      mplier <= in_msg[MUL_WIDTH-1:0];
    end else if (ctl.step) begin
      mcand  <= mcand << shamt;
      mplier <= mplier_next;
    end
  end

  // accumulator, cleared at load
  always_ff @(posedge clk) begin
    if (ctl.load) begin
      acc <= '0;
    end else if (ctl.accumulate) begin
      acc <= acc_sum;
    end
  end

  // status back to control
  assign ctl.mplier_lsb = mplier[0];

  // product straight from the accumulator
  assign out_msg = acc;

endmodule

//--- mul_ctrl.sv
// ------------------------------
// multiplier control FSM
// idle, calc, done with valid/ready on both streams
// ------------------------------

`timescale 1ns/10ps

module mul_ctrl import mul_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       in_val,
  output logic       in_rdy,
  output logic       out_val,
  input  logic       out_rdy,
  mul_ctrl_if.ctrl   ctl
);

  mul_state_t state;
  mul_state_t state_next;

  // stream transfers
  logic in_go;
  logic out_go;

  assign in_go  = in_val && in_rdy;
  assign out_go = out_val && out_rdy;

  // ------------------------------
  // state register
  // ------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= idle;
    end else begin
      state <= state_next;
    end
  end

  // next state
  always_comb begin
    state_next = state;
    case (state)
      idle: begin
        if (in_go) state_next = calc;
      end
      calc: begin
        if (ctl.steps_done) state_next = done;
      end
      done: begin
        if (out_go) state_next = idle;
      end
      default: state_next = idle;
    endcase
  end

  // ------------------------------
  // outputs
  // ------------------------------

  // mealy in calc, steps and adds stop once the count is full
  always_comb begin
    in_rdy         = 1'b0;
    out_val        = 1'b0;
    ctl.load       = 1'b0;
    ctl.step       = 1'b0;
    ctl.accumulate = 1'b0;
    case (state)
      idle: begin
        // operands load whenever idle, kept on transfer
        in_rdy   = 1'b1;
        ctl.load = 1'b1;
      end
      calc: begin
        if (!ctl.steps_done) begin
          ctl.step       = 1'b1;
          ctl.accumulate = ctl.mplier_lsb;
        end
      end
      done: begin
        out_val = 1'b1;
      end
      default: begin
        in_rdy = 1'b0;
      end
    endcase
  end

endmodule

//--- int_mul_var.sv
// ------------------------------
// variable latency integer multiplier
// zero skipping, one operation at a time
// ------------------------------

`timescale 1ns/10ps

module int_mul_var import mul_pkg::*; (
  input  logic                 clk,
  input  logic                 reset,

  // request stream, multiplicand high, multiplier low
  input  logic                 in_val,
  output logic                 in_rdy,
  input  logic [MSG_WIDTH-1:0] in_msg,

  // response stream, low word of the product
  output logic                 out_val,
  input  logic                 out_rdy,
  output logic [MUL_WIDTH-1:0] out_msg
);

  // commands and status between the two units
  mul_ctrl_if ctl_if ();

  // ------------------------------
  // control unit
  // ------------------------------

  // owns the handshake bits of both streams
  mul_ctrl u_ctrl (
    .clk     (clk),
    .reset   (reset),
    .in_val  (in_val),
    .in_rdy  (in_rdy),
    .out_val (out_val),
    .out_rdy (out_rdy),
    .ctl     (ctl_if.ctrl)
  );

  // ------------------------------
  // datapath
  // ------------------------------

  // owns both message payloads
  mul_dpath u_dpath (
    .clk     (clk),
    .reset   (reset),
    .in_msg  (in_msg),
    .out_msg (out_msg),
    .ctl     (ctl_if.dpath)
  );

endmodule

//--- int_mul_props.sv
// ------------------------------
// handshake properties of int_mul_var
// ------------------------------

`timescale 1ns/10ps

module int_mul_props import mul_pkg::*; (
  input logic                 clk,
  input logic                 reset,
  input logic                 in_val,
  input logic                 in_rdy,
  input logic [MSG_WIDTH-1:0] in_msg,
  input logic                 out_val,
  input logic                 out_rdy,
  input logic [MUL_WIDTH-1:0] out_msg
);

  // sender keeps a waiting request steady
  a_in_held: assert property (@(posedge clk) disable iff (reset)
    (in_val && !in_rdy) |=> (in_val && $stable(in_msg)))
    else $error("request dropped or changed while waiting");

  // result stays put under back-pressure
  a_out_held: assert property (@(posedge clk) disable iff (reset)
    (out_val && !out_rdy) |=> (out_val && $stable(out_msg)))
    else $error("result dropped or changed under back-pressure");

  // idle and done never overlap
  a_one_side: assert property (@(posedge clk) disable iff (reset)
    !(in_rdy && out_val))
    else $error("in_rdy and out_val high together");

  // nothing pending right after reset
  a_reset_quiet: assert property (@(posedge clk)
    $past(reset) |-> !out_val)
    else $error("out_val high in the cycle after reset");

endmodule

bind int_mul_var int_mul_props u_props (
  .clk     (clk),
  .reset   (reset),
  .in_val  (in_val),
  .in_rdy  (in_rdy),
  .in_msg  (in_msg),
  .out_val (out_val),
  .out_rdy (out_rdy),
  .out_msg (out_msg)
);

//--- tb_int_mul_var.sv
// ------------------------------
// testbench for int_mul_var
// case file stimulus, back-pressure, latency
// ------------------------------

`timescale 1ns/10ps

module tb_int_mul_var import mul_pkg::*; ();

  localparam int unsigned SEED = 32'h8ff4bbf1;
  localparam int MAX_CASES = 32;
  localparam int CYCLES_PER_CASE = 60;
  localparam int TIMEOUT_MARGIN = 100;
  localparam string CASE_FILE = "mul_cases.txt";

  logic                 clk;
  logic                 reset;
  logic                 in_val;
  logic                 in_rdy;
  logic [MSG_WIDTH-1:0] in_msg;
  logic                 out_val;
  logic                 out_rdy;
  logic [MUL_WIDTH-1:0] out_msg;

  // word 0 holds the case count, then four words per case
  logic [MUL_WIDTH-1:0] case_mem [0:4*MAX_CASES];

  int cycle = 0;
  int timeout_limit = TIMEOUT_MARGIN;
  int errors = 0;
  int checks = 0;

  int_mul_var u_int_mul_var (
    .clk     (clk),
    .reset   (reset),
    .in_val  (in_val),
    .in_rdy  (in_rdy),
    .in_msg  (in_msg),
    .out_val (out_val),
    .out_rdy (out_rdy),
    .out_msg (out_msg)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // run limit
  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= timeout_limit) begin
      $display("timeout: no result after %0d cycles", cycle);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [MUL_WIDTH-1:0] expected,
                             input logic [MUL_WIDTH-1:0] actual);
    checks++;
    assert (actual === expected)
      else begin
        $display("[ERROR] %s: expected 0x%h, actual 0x%h", name, expected, actual);
        errors++;
      end
  endtask

  task automatic check_true(input string what, input logic cond);
    checks++;
    assert (cond === 1'b1)
      else begin
        $display("ERROR: %s", what);
        errors++;
      end
  endtask

  // cycles from request to out_val under the skip rule
  // a one takes a cycle, a zero run up to MAX_SKIP bits takes one
  function automatic int expected_latency(input logic [MUL_WIDTH-1:0] mplier);
    logic [MUL_WIDTH-1:0] m;
    int used;
    int run;
    int cycles;
    m = mplier;
    used = 0;
    cycles = 0;
    while (used < MUL_WIDTH) begin
      run = 0;
      if (m[0]) begin
        m = m >> 1;
        run = 1;
      end else begin
        while (run < MAX_SKIP && run < MUL_WIDTH - used && !m[0]) begin
          m = m >> 1;
          run++;
        end
      end
      used += run;
      cycles++;
    end
    // plus the cycle that sees the count full
    return cycles + 1;
  endfunction

  // ------------------------------
  // main sequence
  // ------------------------------

  initial begin
    logic [MUL_WIDTH-1:0] mcand;
    logic [MUL_WIDTH-1:0] mplier;
    logic [MUL_WIDTH-1:0] product;
    logic [MUL_WIDTH-1:0] held;
    int num_cases;
    int stall;
    int gap;
    int start;
    int lat;
    string name;

    void'($urandom(SEED));
    reset   = 1'b1;
    in_val  = 1'b0;
    in_msg  = '0;
    out_rdy = 1'b0;
    $readmemh(CASE_FILE, case_mem);
    num_cases = int'(case_mem[0]);
    timeout_limit = CYCLES_PER_CASE * num_cases + TIMEOUT_MARGIN;
    check_true("case count in the case file out of range",
               num_cases >= 1 && num_cases <= MAX_CASES);

    repeat (10) @(posedge clk);
    #2;
    reset = 1'b0;
    check_true("in_rdy low after reset", in_rdy);
    check_true("out_val high after reset", !out_val);

    for (int i = 0; i < num_cases && i < MAX_CASES; i++) begin
      mcand   = case_mem[1 + 4*i];
      mplier  = case_mem[2 + 4*i];
      product = case_mem[3 + 4*i];
      stall   = int'(case_mem[4 + 4*i]);
      name    = $sformatf("case %0d", i);
      // every third case goes back to back
      gap = (i % 3 == 2) ? 0 : int'($urandom_range(3, 0));
      repeat (gap) begin
        @(posedge clk);
        #2;
      end

      // request held until accepted
      in_msg = {mcand, mplier};
      in_val = 1'b1;
      while (!in_rdy) begin
        @(posedge clk);
        #2;
      end
      @(posedge clk);
      #2;
      start  = cycle;
      in_val = 1'b0;

      while (!out_val) begin
        check_true({name, ": in_rdy high while busy"}, !in_rdy);
        @(posedge clk);
        #2;
      end
      lat = cycle - start;
      check_value({name, " latency"}, expected_latency(mplier), lat);
      check_true({name, ": latency outside 7 to 33"}, lat >= 7 && lat <= 33);
      check_value({name, " product"}, product, out_msg);
      check_true({name, ": in_rdy high with result pending"}, !in_rdy);

      // next back to back request waits behind the pending result
      if (i + 1 < num_cases && i + 1 < MAX_CASES && (i + 1) % 3 == 2) begin
        in_msg = {case_mem[1 + 4*(i+1)], case_mem[2 + 4*(i+1)]};
        in_val = 1'b1;
      end

      // result must sit still under back-pressure
      held = out_msg;
      repeat (stall) begin
        @(posedge clk);
        #2;
        check_true({name, ": out_val dropped under back-pressure"}, out_val);
        check_true({name, ": in_rdy high under back-pressure"}, !in_rdy);
        check_value({name, " held product"}, held, out_msg);
      end
      out_rdy = 1'b1;
      @(posedge clk);
      #2;
      out_rdy = 1'b0;
      check_true({name, ": out_val still high after transfer"}, !out_val);
      check_true({name, ": in_rdy low after transfer"}, in_rdy);
    end

    $display("checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

//--- mul_cases.txt
// first word: number of cases, in hex
// then per line: multiplicand multiplier product out_rdy-stall-cycles, all hex
00000012
00000000 00000000 00000000 00000000
12345678 00000000 00000000 00000002
00000000 ffffffff 00000000 00000000
00000001 00000001 00000001 00000000
00000001 ffffffff ffffffff 00000003
ffffffff ffffffff 00000001 00000001
ffffffff 00000002 fffffffe 00000000
fffffff9 00000003 ffffffeb 00000000
80000000 00000002 00000000 00000004
00000010 00000100 00001000 00000000
00010000 00010000 00000000 00000001
0000ffff 0000ffff fffe0001 00000000
7fffffff 7fffffff 00000001 00000002
0000abcd 00001234 0c374fa4 00000000
00000007 deadbeef 16c03889 00000005
00000003 55555555 ffffffff 00000000
ffff0000 00010001 ffff0000 00000001
00000003 40000000 c0000000 00000000

//--- vlog.f
mul_pkg.sv
mul_ctrl_if.sv
zero_skip_shifter.sv
step_counter.sv
mul_dpath.sv
mul_ctrl.sv
int_mul_var.sv
int_mul_props.sv
tb_int_mul_var.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the multiplier testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module tb_int_mul_var -f vlog.f -o sim_int_mul_var \
  && ./obj_dir/sim_int_mul_var > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }

cat sim.log
grep -q "FAIL: see errors above" sim.log \
  && { echo "result: failing"; exit 1; } \
  || { echo "result: passing"; exit 0; }
